// ==== design/commit_pkg.sv ====
package commit_pkg;

    // Datapath and register file geometry
    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_LANES      = 2;
    localparam int NUM_READ_PORTS = 4;

    // Exception cause fields
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int EXCP_PAD_W = XLEN - ECODE_W - ESUBCODE_W;

    // What a retiring instruction does to the control flow
    typedef enum logic [1:0] {
        KIND_NORMAL = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_EXCP   = 2'd2,
        KIND_ERTN   = 2'd3
    } lane_kind_e;

    // Cause layout inside the auxiliary word, ecode in the low bits
    typedef struct packed {
        logic [EXCP_PAD_W-1:0] pad;
        logic [ESUBCODE_W-1:0] esubcode;
        logic [ECODE_W-1:0]    ecode;
    } excp_cause_t;

    // Auxiliary word, read as a target for branches and a cause for exceptions
    typedef union packed {
        logic [XLEN-1:0] branch_target;
        excp_cause_t     excp;
    } lane_aux_u;

    // One writeback lane entering commit
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        lane_kind_e            kind;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        lane_aux_u             aux;
    } wb_lane_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } reg_write_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [ECODE_W-1:0]    ecode;
        logic [ESUBCODE_W-1:0] esubcode;
    } excp_event_t;

    // Oldest redirecting lane; target only meaningful for a branch
    typedef struct packed {
        logic            valid;
        lane_kind_e      kind;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [3:0]            rf_wen;
        logic [REG_ADDR_W-1:0] rf_wnum;
        logic [XLEN-1:0]       rf_wdata;
    } trace_t;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                                                 clk,
    input  logic                                                 arst_n_i,
    input  commit_pkg::reg_write_t [commit_pkg::NUM_LANES-1:0]   wr_i,
    input  logic [commit_pkg::NUM_READ_PORTS-1:0]
                 [commit_pkg::REG_ADDR_W-1:0]                    raddr_i,
    output logic [commit_pkg::NUM_READ_PORTS-1:0]
                 [commit_pkg::XLEN-1:0]                          rdata_o
);

    localparam int NUM_REGS = 2 ** commit_pkg::REG_ADDR_W;

    // r0 has no storage
    logic [commit_pkg::XLEN-1:0] regs [1:NUM_REGS-1];

    // Lanes applied in age order so the younger lane wins a shared address
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
                if (wr_i[l].we && (wr_i[l].waddr != '0)) begin
                    regs[wr_i[l].waddr] <= wr_i[l].wdata;
                end
            end
        end
    end

    // Asynchronous read ports
    always_comb begin
        for (int p = 0; p < commit_pkg::NUM_READ_PORTS; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

// ==== design/excp_csr.sv ====
`timescale 1ns/100ps

module excp_csr (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  commit_pkg::excp_event_t             excp_i,
    output logic [commit_pkg::XLEN-1:0]         era_o,
    output logic [commit_pkg::ECODE_W-1:0]      ecode_o
);

    logic [commit_pkg::XLEN-1:0]    era_q;
    logic [commit_pkg::ECODE_W-1:0] ecode_q;

    // Return address of the faulting instruction
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            era_q <= '0;
        end else if (excp_i.valid) begin
            era_q <= excp_i.pc;
        end
    end

    // Last cause, kept until the next exception
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ecode_q <= '0;
        end else if (excp_i.valid) begin
            ecode_q <= excp_i.ecode;
        end
    end

    assign era_o   = era_q;
    assign ecode_o = ecode_q;

endmodule

// ==== design/commit_ctrl.sv ====
`timescale 1ns/100ps

module commit_ctrl (
    input  logic                                              clk,
    input  logic                                              arst_n_i,
    input  commit_pkg::wb_lane_t   [commit_pkg::NUM_LANES-1:0] lanes_i,
    output commit_pkg::reg_write_t [commit_pkg::NUM_LANES-1:0] wr_o,
    output commit_pkg::excp_event_t                            excp_o,
    output commit_pkg::redirect_t                              redirect_o,
    output commit_pkg::trace_t     [commit_pkg::NUM_LANES-1:0] trace_o
);

    localparam int SEL_W = (commit_pkg::NUM_LANES > 1) ? $clog2(commit_pkg::NUM_LANES) : 1;

    logic [commit_pkg::NUM_LANES-1:0] live;
    logic [commit_pkg::NUM_LANES-1:0] redir;
    logic [SEL_W-1:0]                 sel_idx;
    commit_pkg::wb_lane_t             sel_lane;
    commit_pkg::trace_t [commit_pkg::NUM_LANES-1:0] trace_d;

    // A redirecting lane kills every younger lane behind it
    always_comb begin : squash
        logic blocked;
        blocked = 1'b0;
        for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
            redir[l] = lanes_i[l].kind != commit_pkg::KIND_NORMAL;
            live[l]  = lanes_i[l].valid && !blocked;
            blocked  = blocked | (live[l] & redir[l]);
        end
    end

    // Only normal and branch lanes touch the register file
    always_comb begin
        for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
            wr_o[l].we    = live[l]
                          && ((lanes_i[l].kind == commit_pkg::KIND_NORMAL)
                              || (lanes_i[l].kind == commit_pkg::KIND_BRANCH))
                          && lanes_i[l].we
                          && (lanes_i[l].waddr != '0);
            wr_o[l].waddr = lanes_i[l].waddr;
            wr_o[l].wdata = lanes_i[l].wdata;
        end
    end

    // Oldest live redirecting lane, scanned youngest first
    always_comb begin
        sel_idx = '0;
        for (int l = commit_pkg::NUM_LANES - 1; l >= 0; l--) begin
            if (live[l] && redir[l]) begin
                sel_idx = SEL_W'(l);
            end
        end
    end

    assign sel_lane = lanes_i[sel_idx];

    assign redirect_o.valid  = |(live & redir);
    assign redirect_o.kind   = sel_lane.kind;
    // aux is a target only on a branch lane
    assign redirect_o.target = (sel_lane.kind == commit_pkg::KIND_BRANCH)
                             ? sel_lane.aux.branch_target : '0;

    // On an exception lane the same word carries the cause
    assign excp_o.valid    = redirect_o.valid && (sel_lane.kind == commit_pkg::KIND_EXCP);
    assign excp_o.pc       = sel_lane.pc;
    assign excp_o.ecode    = sel_lane.aux.excp.ecode;
    assign excp_o.esubcode = sel_lane.aux.excp.esubcode;

    // Debug trace, exceptions do not retire
    always_comb begin
        for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
            trace_d[l].valid    = live[l] && (lanes_i[l].kind != commit_pkg::KIND_EXCP);
            trace_d[l].pc       = lanes_i[l].pc;
            trace_d[l].rf_wen   = {3'b000, wr_o[l].we};
            trace_d[l].rf_wnum  = lanes_i[l].waddr;
            trace_d[l].rf_wdata = lanes_i[l].wdata;
        end
    end

    // One cycle behind commit
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trace_o <= '0;
        end else begin
            trace_o <= trace_d;
        end
    end

endmodule

// ==== design/redirect_gen.sv ====
`timescale 1ns/100ps

module redirect_gen #(
    parameter logic [commit_pkg::XLEN-1:0] EENTRY = 32'h1c008000
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  commit_pkg::redirect_t         redirect_i,
    input  logic [commit_pkg::XLEN-1:0]   era_i,
    output logic                          flush_o,
    output logic [commit_pkg::XLEN-1:0]   next_pc_o
);

    logic [commit_pkg::XLEN-1:0] target_d;

    // Exception entry, then return address, then branch target
    always_comb begin
        case (redirect_i.kind)
            commit_pkg::KIND_EXCP: target_d = EENTRY;
            // era before this edge's update
            commit_pkg::KIND_ERTN: target_d = era_i;
            default:               target_d = redirect_i.target;
        endcase
        if (!redirect_i.valid) begin
            target_d = '0;
        end
    end

    // Single-cycle flush pulse with its PC
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flush_o   <= 1'b0;
            next_pc_o <= '0;
        end else begin
            flush_o   <= redirect_i.valid;
            next_pc_o <= target_d;
        end
    end

endmodule

// ==== design/commit_top.sv ====
`timescale 1ns/100ps

module commit_top #(
    parameter logic [commit_pkg::XLEN-1:0] EENTRY = 32'h1c008000
) (
    input  logic                                                clk,
    input  logic                                                arst_n_i,
    input  commit_pkg::wb_lane_t [commit_pkg::NUM_LANES-1:0]    lanes_i,
    input  logic [commit_pkg::NUM_READ_PORTS-1:0]
                 [commit_pkg::REG_ADDR_W-1:0]                   raddr_i,
    output logic [commit_pkg::NUM_READ_PORTS-1:0]
                 [commit_pkg::XLEN-1:0]                         rdata_o,
    output logic                                                flush_o,
    output logic [commit_pkg::XLEN-1:0]                         next_pc_o,
    output logic [commit_pkg::XLEN-1:0]                         era_o,
    output logic [commit_pkg::ECODE_W-1:0]                      ecode_o,
    output commit_pkg::trace_t [commit_pkg::NUM_LANES-1:0]      trace_o
);

    // Commit controller fan-out
    commit_pkg::reg_write_t [commit_pkg::NUM_LANES-1:0] reg_wr;
    commit_pkg::excp_event_t                            excp_evt;
    commit_pkg::redirect_t                              redirect;

    commit_ctrl u_commit_ctrl (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .lanes_i    (lanes_i),
        .wr_o       (reg_wr),
        .excp_o     (excp_evt),
        .redirect_o (redirect),
        .trace_o    (trace_o)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (reg_wr),
        .raddr_i  (raddr_i),
        .rdata_o  (rdata_o)
    );

    // era also feeds the return path of the redirect logic
    excp_csr u_excp_csr (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .excp_i   (excp_evt),
        .era_o    (era_o),
        .ecode_o  (ecode_o)
    );

    redirect_gen #(
        .EENTRY (EENTRY)
    ) u_redirect_gen (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .redirect_i (redirect),
        .era_i      (era_o),
        .flush_o    (flush_o),
        .next_pc_o  (next_pc_o)
    );

endmodule

// ==== tests/commit_tb_assertions.sv ====
`timescale 1ns/100ps

module commit_tb_assertions (
    input logic                                           clk,
    input logic                                           arst_n_i,
    input logic                                           flush_i,
    input commit_pkg::trace_t [commit_pkg::NUM_LANES-1:0] trace_i
);

    logic [commit_pkg::NUM_LANES-1:0] trace_valid;
    logic [commit_pkg::NUM_LANES-1:0] wen_upper;
    logic [commit_pkg::NUM_LANES-1:0] wen_low;

    always_comb begin
        for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
            trace_valid[l] = trace_i[l].valid;
            wen_upper[l]   = |trace_i[l].rf_wen[3:1];
            wen_low[l]     = trace_i[l].rf_wen[0];
        end
    end

    // Flush is a single-cycle pulse
    flush_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n_i) flush_i |=> !flush_i
    ) else $error("flush_o was high on two cycles in a row");

    // No retirement is reported while in reset
    trace_idle_in_reset: assert property (
        @(posedge clk) !arst_n_i |-> (trace_valid == '0)
    ) else $error("trace valid seen during reset");

    // A write shows only in bit 0 of rf_wen and only on a valid trace
    wen_well_formed: assert property (
        @(posedge clk) disable iff (!arst_n_i)
            (wen_upper == '0) && ((wen_low & ~trace_valid) == '0)
    ) else $error("rf_wen upper bits set or write reported without a valid trace");

endmodule

// ==== tests/commit_tb.sv ====
`timescale 1ns/100ps

module commit_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_DIRECTED = 10;
    localparam int NUM_RANDOM   = 400;
    localparam int MARGIN       = 50;
    // Each drive may be preceded by one bubble after a redirect
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * (NUM_DIRECTED + NUM_RANDOM) + MARGIN;
    localparam logic [31:0] LFSR_SEED = 32'h563d;
    localparam logic [commit_pkg::XLEN-1:0] EENTRY = 32'h1c01_0000;

    typedef struct packed {
        logic [commit_pkg::NUM_LANES-1:0]                              wr_en;
        logic [commit_pkg::NUM_LANES-1:0][commit_pkg::REG_ADDR_W-1:0] wr_addr;
        logic [commit_pkg::NUM_LANES-1:0][commit_pkg::XLEN-1:0]       wr_data;
        logic                                                          excp_valid;
        logic [commit_pkg::XLEN-1:0]                                   excp_pc;
        logic [commit_pkg::ECODE_W-1:0]                                excp_ecode;
        logic                                                          flush;
        logic [commit_pkg::XLEN-1:0]                                   next_pc;
        commit_pkg::trace_t [commit_pkg::NUM_LANES-1:0]                trace;
    } model_out_t;

    logic clk;
    logic arst_n;
    commit_pkg::wb_lane_t [commit_pkg::NUM_LANES-1:0] lanes;
    logic [commit_pkg::NUM_READ_PORTS-1:0][commit_pkg::REG_ADDR_W-1:0] raddr;
    logic [commit_pkg::NUM_READ_PORTS-1:0][commit_pkg::XLEN-1:0]       rdata;
    logic                                  flush;
    logic [commit_pkg::XLEN-1:0]           next_pc;
    logic [commit_pkg::XLEN-1:0]           era;
    logic [commit_pkg::ECODE_W-1:0]        ecode;
    commit_pkg::trace_t [commit_pkg::NUM_LANES-1:0] trace;

    // Reference state
    logic [commit_pkg::XLEN-1:0]    model_regs [0:31];
    logic [commit_pkg::XLEN-1:0]    model_era;
    logic [commit_pkg::ECODE_W-1:0] model_ecode;

    logic [31:0] lfsr_state;
    logic        prev_redirect;

    commit_top #(
        .EENTRY (EENTRY)
    ) dut0 (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .lanes_i   (lanes),
        .raddr_i   (raddr),
        .rdata_o   (rdata),
        .flush_o   (flush),
        .next_pc_o (next_pc),
        .era_o     (era),
        .ecode_o   (ecode),
        .trace_o   (trace)
    );

    bind commit_top commit_tb_assertions u_assertions (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_o),
        .trace_i  (trace_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Expected outcome of one commit edge from the commit rules
    function automatic model_out_t commit_model(
        input commit_pkg::wb_lane_t [commit_pkg::NUM_LANES-1:0] ln,
        input logic [commit_pkg::XLEN-1:0]                      era_now
    );
        model_out_t r;
        logic       older_redirect;
        logic       live;
        logic       writes;
        r = '0;
        older_redirect = 1'b0;
        for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
            live   = ln[l].valid && !older_redirect;
            writes = live && ln[l].we && (ln[l].waddr != '0)
                     && ((ln[l].kind == commit_pkg::KIND_NORMAL)
                         || (ln[l].kind == commit_pkg::KIND_BRANCH));
            r.wr_en[l]   = writes;
            r.wr_addr[l] = ln[l].waddr;
            r.wr_data[l] = ln[l].wdata;
            r.trace[l].valid    = live && (ln[l].kind != commit_pkg::KIND_EXCP);
            r.trace[l].pc       = ln[l].pc;
            r.trace[l].rf_wen   = {3'b000, writes};
            r.trace[l].rf_wnum  = ln[l].waddr;
            r.trace[l].rf_wdata = ln[l].wdata;
            // Oldest live redirect decides and everything younger is dead
            if (live && (ln[l].kind != commit_pkg::KIND_NORMAL)) begin
                older_redirect = 1'b1;
                r.flush = 1'b1;
                case (ln[l].kind)
                    commit_pkg::KIND_EXCP: begin
                        r.next_pc    = EENTRY;
                        r.excp_valid = 1'b1;
                        r.excp_pc    = ln[l].pc;
                        r.excp_ecode = ln[l].aux.excp.ecode;
                    end
                    commit_pkg::KIND_ERTN: r.next_pc = era_now;
                    default:               r.next_pc = ln[l].aux.branch_target;
                endcase
            end
        end
        return r;
    endfunction

    function automatic commit_pkg::wb_lane_t make_lane(
        input logic [31:0] pc, input commit_pkg::lane_kind_e kind, input logic we,
        input logic [4:0] waddr, input logic [31:0] wdata, input logic [31:0] aux
    );
        commit_pkg::wb_lane_t ln;
        ln.valid = 1'b1;
        ln.pc    = pc;
        ln.kind  = kind;
        ln.we    = we;
        ln.waddr = waddr;
        ln.wdata = wdata;
        ln.aux.branch_target = aux;
        return ln;
    endfunction

    function automatic logic [31:0] excp_aux(input logic [5:0] ec, input logic [8:0] esc);
        commit_pkg::lane_aux_u a;
        a = '0;
        a.excp.ecode    = ec;
        a.excp.esubcode = esc;
        return a.branch_target;
    endfunction

    // A bubble follows every redirect, as wrong-path work never arrives
    task automatic drive_cycle(input commit_pkg::wb_lane_t l0, input commit_pkg::wb_lane_t l1,
                               input logic [19:0] rd);
        @(negedge clk);
        if (prev_redirect) begin
            lanes = '0;
            @(negedge clk);
        end
        lanes[0] = l0;
        lanes[1] = l1;
        raddr    = rd;
        prev_redirect = (l0.valid && (l0.kind != commit_pkg::KIND_NORMAL))
                        || (l1.valid && (l1.kind != commit_pkg::KIND_NORMAL));
    endtask

    task automatic random_lane(output commit_pkg::wb_lane_t ln);
        logic [31:0] v;
        ln = '0;
        take_bits(3, v);
        ln.valid = (v[2:0] != 3'd0);
        take_bits(30, v);
        ln.pc = {v[29:0], 2'b00};
        take_bits(4, v);
        if (v[3:0] < 4'd9) begin
            ln.kind = commit_pkg::KIND_NORMAL;
        end else if (v[3:0] < 4'd12) begin
            ln.kind = commit_pkg::KIND_BRANCH;
        end else if (v[3:0] < 4'd14) begin
            ln.kind = commit_pkg::KIND_EXCP;
        end else begin
            ln.kind = commit_pkg::KIND_ERTN;
        end
        take_bits(1, v);
        ln.we = v[0];
        take_bits(5, v);
        ln.waddr = v[4:0];
        take_bits(32, v);
        ln.wdata = v;
        take_bits(32, v);
        ln.aux.branch_target = v;
    endtask

    task automatic run_directed();
        commit_pkg::wb_lane_t idle;
        idle = '0;
        // Plain writes, then a shared address, then r0
        drive_cycle(make_lane(32'h1000, commit_pkg::KIND_NORMAL, 1'b1, 5'd3, 32'haaaa_0003, 0),
                    make_lane(32'h1004, commit_pkg::KIND_NORMAL, 1'b1, 5'd5, 32'h5555_0005, 0),
                    {5'd0, 5'd7, 5'd5, 5'd3});
        drive_cycle(make_lane(32'h1008, commit_pkg::KIND_NORMAL, 1'b1, 5'd7, 32'h7000_0000, 0),
                    make_lane(32'h100c, commit_pkg::KIND_NORMAL, 1'b1, 5'd7, 32'h7777_7777, 0),
                    {5'd7, 5'd3, 5'd5, 5'd0});
        drive_cycle(make_lane(32'h1010, commit_pkg::KIND_NORMAL, 1'b1, 5'd0, 32'hdead_beef, 0),
                    make_lane(32'h1014, commit_pkg::KIND_NORMAL, 1'b0, 5'd9, 32'h9999_9999, 0),
                    {5'd0, 5'd9, 5'd7, 5'd0});
        // Exception in lane 0 kills lane 1
        drive_cycle(make_lane(32'h2000, commit_pkg::KIND_EXCP, 1'b1, 5'd11, 32'h1111_1111,
                              excp_aux(6'h0d, 9'h003)),
                    make_lane(32'h2004, commit_pkg::KIND_NORMAL, 1'b1, 5'd12, 32'h1212_1212, 0),
                    {5'd3, 5'd0, 5'd12, 5'd11});
        // Exception in lane 1 behind a retiring lane 0
        drive_cycle(make_lane(32'h3000, commit_pkg::KIND_NORMAL, 1'b1, 5'd13, 32'h1313_1313, 0),
                    make_lane(32'h3004, commit_pkg::KIND_EXCP, 1'b0, 5'd0, 0,
                              excp_aux(6'h08, 9'h000)),
                    {5'd0, 5'd0, 5'd0, 5'd13});
        // Returns to the captured era
        drive_cycle(make_lane(32'h4000, commit_pkg::KIND_ERTN, 1'b1, 5'd14, 32'h1414_1414, 0),
                    make_lane(32'h4004, commit_pkg::KIND_NORMAL, 1'b1, 5'd15, 32'h1515_1515, 0),
                    {5'd0, 5'd13, 5'd15, 5'd14});
        drive_cycle(make_lane(32'h4100, commit_pkg::KIND_NORMAL, 1'b1, 5'd16, 32'h1616_1616, 0),
                    make_lane(32'h4104, commit_pkg::KIND_ERTN, 1'b0, 5'd0, 0, 0),
                    {5'd0, 5'd0, 5'd14, 5'd16});
        // Branches in either lane
        drive_cycle(make_lane(32'h5000, commit_pkg::KIND_BRANCH, 1'b1, 5'd1, 32'h5004, 32'h6000),
                    make_lane(32'h5004, commit_pkg::KIND_NORMAL, 1'b1, 5'd2, 32'h0202_0202, 0),
                    {5'd0, 5'd0, 5'd2, 5'd1});
        drive_cycle(make_lane(32'h6000, commit_pkg::KIND_NORMAL, 1'b1, 5'd4, 32'h0404_0404, 0),
                    make_lane(32'h6004, commit_pkg::KIND_BRANCH, 1'b1, 5'd6, 32'h6008, 32'h7100),
                    {5'd0, 5'd2, 5'd6, 5'd4});
        drive_cycle(idle,
                    make_lane(32'h7100, commit_pkg::KIND_NORMAL, 1'b1, 5'd8, 32'h0808_0808, 0),
                    {5'd1, 5'd4, 5'd6, 5'd8});
    endtask

    initial begin : compare
        model_out_t m;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        model_era   = '0;
        model_ecode = '0;
        @(posedge arst_n);
        check_value("flush_o", 32'(flush), 32'd0);
        check_value("next_pc_o", next_pc, 32'd0);
        check_value("era_o", era, 32'd0);
        check_value("ecode_o", 32'(ecode), 32'd0);
        for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
            check_value($sformatf("trace_o[%0d].valid", l), 32'(trace[l].valid), 32'd0);
        end
        forever begin
            @(posedge clk);
            #1;
            m = commit_model(lanes, model_era);
            for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
                if (m.wr_en[l]) begin
                    model_regs[m.wr_addr[l]] = m.wr_data[l];
                end
            end
            if (m.excp_valid) begin
                model_era   = m.excp_pc;
                model_ecode = m.excp_ecode;
            end
            check_value("flush_o", 32'(flush), 32'(m.flush));
            if (m.flush) begin
                check_value("next_pc_o", next_pc, m.next_pc);
            end
            check_value("era_o", era, model_era);
            check_value("ecode_o", 32'(ecode), 32'(model_ecode));
            for (int p = 0; p < commit_pkg::NUM_READ_PORTS; p++) begin
                check_value($sformatf("rdata_o[%0d]", p), rdata[p], model_regs[raddr[p]]);
            end
            for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
                check_value($sformatf("trace_o[%0d].valid", l),
                            32'(trace[l].valid), 32'(m.trace[l].valid));
                if (m.trace[l].valid) begin
                    check_value($sformatf("trace_o[%0d].pc", l), trace[l].pc, m.trace[l].pc);
                    check_value($sformatf("trace_o[%0d].rf_wen", l),
                                32'(trace[l].rf_wen), 32'(m.trace[l].rf_wen));
                    check_value($sformatf("trace_o[%0d].rf_wnum", l),
                                32'(trace[l].rf_wnum), 32'(m.trace[l].rf_wnum));
                    check_value($sformatf("trace_o[%0d].rf_wdata", l),
                                trace[l].rf_wdata, m.trace[l].rf_wdata);
                end
            end
        end
    end

    initial begin : stimulus
        commit_pkg::wb_lane_t l0;
        commit_pkg::wb_lane_t l1;
        logic [31:0]          v;
        lanes         = '0;
        raddr         = '0;
        arst_n        = 1'b0;
        prev_redirect = 1'b0;
        lfsr_state    = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        run_directed();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_lane(l0);
            random_lane(l1);
            take_bits(20, v);
            drive_cycle(l0, l1, v[19:0]);
        end
        @(negedge clk);
        lanes = '0;
        // Let the last commit reach the compare process
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
design/commit_pkg.sv
design/regfile.sv
design/excp_csr.sv
design/commit_ctrl.sv
design/redirect_gen.sv
design/commit_top.sv
tests/commit_tb_assertions.sv
tests/commit_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := commit_tb
FILE_LIST  := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

# Static checks of the whole file list
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# Build and run; the exit status is nonzero when the run fails
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
